//--- hdl/csr_index_pkg.sv
// --------------------
// Shared types for the CSR index generator
// Indices, strides and addresses are all INDEX_W bits wide
// Address arithmetic wraps silently at INDEX_W bits
// --------------------

package csr_index_pkg;

    localparam int INDEX_W = 32;
    localparam int SHIFT_W = 5;

    // Host range configuration
    typedef struct packed {
        logic [INDEX_W-1:0] array_pointer;
        logic [INDEX_W-1:0] index_start;
        logic [INDEX_W-1:0] index_end;
        logic [INDEX_W-1:0] stride;
        logic               count_down;
        logic               shift_left;
        logic [SHIFT_W-1:0] shift_amount;
    } range_config_t;

    // Walking job for the sequencer, stride never zero
    typedef struct packed {
        logic [INDEX_W-1:0] first;
        logic [INDEX_W-1:0] limit;
        logic [INDEX_W-1:0] stride;
        logic               count_down;
    } seq_job_t;

    // Address mapping held by the queue
    typedef struct packed {
        logic [INDEX_W-1:0] base;
        logic               shift_left;
        logic [SHIFT_W-1:0] shift_amount;
    } addr_map_t;

    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic               last;
    } seq_item_t;

    typedef struct packed {
        logic [INDEX_W-1:0] address;
        logic [INDEX_W-1:0] index;
        logic               last;
    } mem_request_t;

endpackage

//--- hdl/range_decode.sv
// --------------------
// Four-phase configuration intake
// cfg must stay stable while cfg_req is high
// A request is held off until seq_idle is high
// --------------------

module range_decode import csr_index_pkg::*; (
    input  logic          ap_clk,
    input  logic          areset_generator,
    input  range_config_t cfg,
    input  logic          cfg_req,
    output logic          cfg_ack,
    input  logic          seq_idle,
    output seq_job_t      job,
    output logic          job_start,
    output addr_map_t     addr_map
);

    logic accept;

    // New config only with a fresh request and an idle generator
    assign accept = cfg_req & ~cfg_ack & seq_idle;

    // --------------------
    // Handshake
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg_ack   <= 1'b0;
            job_start <= 1'b0;
        end else begin
            job_start <= accept;
            if (accept) begin
                cfg_ack <= 1'b1;
            end else if (cfg_ack && !cfg_req) begin
                // Host has released the request
                cfg_ack <= 1'b0;
            end
        end
    end

    // --------------------
    // Config split
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            job.first      <= cfg.index_start;
            job.limit      <= cfg.index_end;
            job.count_down <= cfg.count_down;
            // Zero stride would never finish
            if (cfg.stride == '0) begin
                job.stride <= INDEX_W'(1);
            end else begin
                job.stride <= cfg.stride;
            end
            addr_map.base         <= cfg.array_pointer;
            addr_map.shift_left   <= cfg.shift_left;
            addr_map.shift_amount <= cfg.shift_amount;
        end
    end

endmodule : range_decode

//--- hdl/index_sequencer.sv
// --------------------
// Walks the job range one stride per cycle
// job must stay stable until the sequencer is idle again
// Stops emitting while prog_full is high
// --------------------

module index_sequencer import csr_index_pkg::*; (
    input  logic      ap_clk,
    input  logic      areset_generator,
    input  seq_job_t  job,
    input  logic      job_start,
    input  logic      prog_full,
    output logic      seq_idle,
    output seq_item_t item,
    output logic      item_valid
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_BUSY,
        SEQ_PAUSE,
        SEQ_FINISH
    } seq_state_t;

    seq_state_t         state;
    logic [INDEX_W-1:0] count;

    // Index still inside the range in the job's direction
    function automatic logic inside_range(input logic [INDEX_W-1:0] value,
                                          input seq_job_t           j);
        if (j.count_down) begin
            return value > j.limit;
        end
        return value < j.limit;
    endfunction

    // One stride ahead, with wrap flagged in the top bit
    function automatic logic [INDEX_W:0] step(input logic [INDEX_W-1:0] value,
                                              input seq_job_t           j);
        if (j.count_down) begin
            return {1'b0, value} - {1'b0, j.stride};
        end
        return {1'b0, value} + {1'b0, j.stride};
    endfunction

    // True when value is the final index of the range
    function automatic logic is_last(input logic [INDEX_W-1:0] value,
                                     input seq_job_t           j);
        logic [INDEX_W:0] nxt;
        nxt = step(value, j);
        return nxt[INDEX_W] | ~inside_range(nxt[INDEX_W-1:0], j);
    endfunction

    assign seq_idle = (state == SEQ_IDLE);

    // --------------------
    // FSM and stride counter
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state      <= SEQ_IDLE;
            item_valid <= 1'b0;
        end else begin
            item_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (job_start) begin
                        if (!inside_range(job.first, job)) begin
                            state <= SEQ_FINISH;
                        end else begin
                            // First index goes out right away
                            item_valid <= 1'b1;
                            state      <= is_last(job.first, job) ? SEQ_FINISH : SEQ_BUSY;
                        end
                    end
                end
                SEQ_BUSY: begin
                    if (prog_full) begin
                        state <= SEQ_PAUSE;
                    end else begin
                        item_valid <= 1'b1;
                        if (is_last(count, job)) begin
                            state <= SEQ_FINISH;
                        end
                    end
                end
                SEQ_PAUSE: begin
                    if (!prog_full) begin
                        state <= SEQ_BUSY;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Item payload and count carry no reset
    always_ff @(posedge ap_clk) begin
        if (state == SEQ_IDLE && job_start) begin
            item.index <= job.first;
            item.last  <= is_last(job.first, job);
            count      <= INDEX_W'(step(job.first, job));
        end else if (state == SEQ_BUSY && !prog_full) begin
            item.index <= count;
            item.last  <= is_last(count, job);
            count      <= INDEX_W'(step(count, job));
        end
    end

endmodule : index_sequencer

//--- hdl/request_queue.sv
// --------------------
// Address stage plus first-word-fall-through FIFO
// FIFO_DEPTH - PROG_THRESH must be at least 4 to absorb items in flight
// empty covers the address stage as well as the FIFO
// --------------------

module request_queue import csr_index_pkg::*; #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  addr_map_t    addr_map,
    input  seq_item_t    item,
    input  logic         item_valid,
    output logic         prog_full,
    output logic         empty,
    output mem_request_t request,
    output logic         request_valid,
    input  logic         request_rd_en
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [INDEX_W-1:0] offset;
    mem_request_t       stage;
    logic               stage_valid;

    mem_request_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   occupancy;
    logic               push;
    logic               pop;

    // --------------------
    // Address stage
    // --------------------
    always_comb begin
        if (addr_map.shift_left) begin
            offset = item.index << addr_map.shift_amount;
        end else begin
            offset = item.index >> addr_map.shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= item_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (item_valid) begin
            stage.address <= addr_map.base + offset;
            stage.index   <= item.index;
            stage.last    <= item.last;
        end
    end

    // --------------------
    // FIFO
    // --------------------
    assign push = stage_valid;
    assign pop  = request_valid & request_rd_en;

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= stage;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Head entry shows without a read
    assign request       = mem[rd_ptr];
    assign request_valid = (occupancy != '0);

    assign prog_full = (occupancy >= CNT_W'(PROG_THRESH));
    assign empty     = ~request_valid & ~stage_valid;

endmodule : request_queue

//--- hdl/csr_index_gen_top.sv
// --------------------
// CSR edge index generator, direct mode only
// One job at a time, the next config waits for done_out
// --------------------

module csr_index_gen_top import csr_index_pkg::*; #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic          ap_clk,
    input  logic          areset_generator,
    input  range_config_t cfg,
    input  logic          cfg_req,
    output logic          cfg_ack,
    output mem_request_t  request,
    output logic          request_valid,
    input  logic          request_rd_en,
    output logic          done_out
);

    seq_job_t  job;
    addr_map_t addr_map;
    seq_item_t item;
    logic      job_start;
    logic      seq_idle;
    logic      gen_idle;
    logic      item_valid;
    logic      prog_full;
    logic      queue_empty;
    logic      job_open;

    // Idle only once the whole job has drained
    assign gen_idle = seq_idle & ~job_open;

    range_decode decode_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg             (cfg),
        .cfg_req         (cfg_req),
        .cfg_ack         (cfg_ack),
        .seq_idle        (gen_idle),
        .job             (job),
        .job_start       (job_start),
        .addr_map        (addr_map)
    );

    index_sequencer sequencer_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .job             (job),
        .job_start       (job_start),
        .prog_full       (prog_full),
        .seq_idle        (seq_idle),
        .item            (item),
        .item_valid      (item_valid)
    );

    request_queue #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) queue_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .addr_map        (addr_map),
        .item            (item),
        .item_valid      (item_valid),
        .prog_full       (prog_full),
        .empty           (queue_empty),
        .request         (request),
        .request_valid   (request_valid),
        .request_rd_en   (request_rd_en)
    );

    // --------------------
    // Done tracking
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            job_open <= 1'b0;
            done_out <= 1'b0;
        end else if (job_start) begin
            // Pulses with the rise of cfg_ack
            job_open <= 1'b1;
            done_out <= 1'b0;
        end else if (job_open && seq_idle && queue_empty) begin
            // Last request popped, or nothing to emit
            job_open <= 1'b0;
            done_out <= 1'b1;
        end
    end

endmodule : csr_index_gen_top

//--- test/csr_index_gen_assert.sv
// --------------------
// Protocol and ordering checks, bound into csr_index_gen_top
// Expected values restart at every rise of cfg_ack
// error_count is read by the testbench
// --------------------

module csr_index_gen_assert import csr_index_pkg::*; (
    input logic          ap_clk,
    input logic          areset_generator,
    input range_config_t cfg,
    input logic          cfg_req,
    input logic          cfg_ack,
    input mem_request_t  request,
    input logic          request_valid,
    input logic          request_rd_en,
    input logic          done_out
);

    range_config_t      cfg_q;
    logic               ack_d;
    logic               ack_rise;
    logic               pop;
    logic               running;
    logic [INDEX_W-1:0] exp_index;
    logic [INDEX_W-1:0] exp_addr;
    logic [INDEX_W-1:0] exp_stride;
    int unsigned        pop_count;
    int unsigned        exp_count;
    int                 error_count = 0;

    // Requests expected for a range, rounded up
    function automatic int unsigned range_count(input range_config_t c);
        longint unsigned span;
        longint unsigned step_size;
        step_size = (c.stride == '0) ? 1 : c.stride;
        span = 0;
        if (c.count_down && c.index_start > c.index_end) begin
            span = c.index_start - c.index_end;
        end
        if (!c.count_down && c.index_end > c.index_start) begin
            span = c.index_end - c.index_start;
        end
        return int'((span + step_size - 1) / step_size);
    endfunction

    assign ack_rise   = cfg_ack & ~ack_d;
    assign pop        = request_valid & request_rd_en;
    assign exp_stride = (cfg_q.stride == '0) ? INDEX_W'(1) : cfg_q.stride;
    assign exp_count  = range_count(cfg_q);

    always_comb begin
        if (cfg_q.shift_left) begin
            exp_addr = cfg_q.array_pointer + (exp_index << cfg_q.shift_amount);
        end else begin
            exp_addr = cfg_q.array_pointer + (exp_index >> cfg_q.shift_amount);
        end
    end

    // --------------------
    // Reference model
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            ack_d     <= 1'b0;
            running   <= 1'b0;
            pop_count <= 0;
        end else begin
            ack_d <= cfg_ack;
            if (ack_rise) begin
                running   <= 1'b1;
                pop_count <= 0;
            end else begin
                if (done_out) begin
                    running <= 1'b0;
                end
                if (pop) begin
                    pop_count <= pop_count + 1;
                end
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (ack_rise) begin
            cfg_q     <= cfg;
            exp_index <= cfg.index_start;
        end else if (pop) begin
            exp_index <= cfg_q.count_down ? exp_index - exp_stride : exp_index + exp_stride;
        end
    end

    // --------------------
    // Handshake and done
    // --------------------
    reset_quiet_a: assert property (@(posedge ap_clk)
        areset_generator |=> (!cfg_ack && !request_valid && !done_out))
        else begin
            $error("Outputs not low after reset");
            error_count++;
        end

    ack_needs_req_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(cfg_ack) |-> $past(cfg_req))
        else begin
            $error("cfg_ack rose without cfg_req");
            error_count++;
        end

    ack_drop_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $fell(cfg_ack) |-> !$past(cfg_req))
        else begin
            $error("cfg_ack fell while cfg_req was still high");
            error_count++;
        end

    ack_idle_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(cfg_ack) |-> !running)
        else begin
            $error("Configuration accepted while a job was running");
            error_count++;
        end

    done_clear_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(cfg_ack) |=> !done_out)
        else begin
            $error("done_out stayed high after a new configuration");
            error_count++;
        end

    // --------------------
    // Request stream
    // --------------------
    index_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> request.index == exp_index)
        else begin
            $error("FAILED request.index got %h expected %h", request.index, exp_index);
            error_count++;
        end

    address_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> request.address == exp_addr)
        else begin
            $error("FAILED request.address got %h expected %h", request.address, exp_addr);
            error_count++;
        end

    last_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> request.last == (pop_count + 1 == exp_count))
        else begin
            $error("FAILED request.last got %h expected %h", request.last,
                   pop_count + 1 == exp_count);
            error_count++;
        end

    count_a: assert property (@(posedge ap_clk) disable iff (areset_generator)
        $rose(done_out) |-> pop_count == exp_count)
        else begin
            $error("FAILED pop_count got %h expected %h", pop_count, exp_count);
            error_count++;
        end

endmodule : csr_index_gen_assert

bind csr_index_gen_top csr_index_gen_assert assert_i (.*);

//--- test/csr_index_gen_tb.sv
// --------------------
// Drives the generator through its jobs
// The bound checker does the comparing
// Pops are random unless held off
// --------------------

module csr_index_gen_tb import csr_index_pkg::*; ();

    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;
    localparam int WAIT_LIMIT  = 1000;

    logic          ap_clk;
    logic          areset_generator;
    range_config_t cfg;
    logic          cfg_req;
    logic          cfg_ack;
    mem_request_t  request;
    logic          request_valid;
    logic          request_rd_en;
    logic          done_out;
    logic          hold_rd;
    int            seed = 43;

    csr_index_gen_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) dut_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg             (cfg),
        .cfg_req         (cfg_req),
        .cfg_ack         (cfg_ack),
        .request         (request),
        .request_valid   (request_valid),
        .request_rd_en   (request_rd_en),
        .done_out        (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    task automatic fail_run(input string reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    // Consumer side
    always @(posedge ap_clk) begin
        if (hold_rd) begin
            request_rd_en <= 1'b0;
        end else begin
            request_rd_en <= ($random(seed) % 2) != 0;
        end
    end

    // Stop at the first checker error
    always @(posedge ap_clk) begin
        if (dut_i.assert_i.error_count != 0) begin
            fail_run("A checker assertion reported an error");
        end
    end

    function automatic range_config_t make_config(
        input logic [INDEX_W-1:0] pointer,
        input logic [INDEX_W-1:0] start,
        input logic [INDEX_W-1:0] stop,
        input logic [INDEX_W-1:0] stride,
        input logic               down,
        input logic               left,
        input logic [SHIFT_W-1:0] amount
    );
        range_config_t c;
        c.array_pointer = pointer;
        c.index_start   = start;
        c.index_end     = stop;
        c.stride        = stride;
        c.count_down    = down;
        c.shift_left    = left;
        c.shift_amount  = amount;
        return c;
    endfunction

    task automatic wait_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (cfg_ack !== level && cycles < WAIT_LIMIT) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (cfg_ack !== level) begin
            fail_run($sformatf("Timed out waiting for cfg_ack to %s", what));
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_out !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (done_out !== 1'b1) begin
            fail_run("Timed out waiting for done_out");
        end
    endtask

    // Full four-phase exchange
    task automatic send_config(input range_config_t c);
        @(posedge ap_clk);
        cfg     <= c;
        cfg_req <= 1'b1;
        wait_ack(1'b1, "rise");
        cfg_req <= 1'b0;
        wait_ack(1'b0, "fall");
    endtask

    initial begin
        areset_generator = 1'b1;
        cfg              = '0;
        cfg_req          = 1'b0;
        request_rd_en    = 1'b0;
        hold_rd          = 1'b0;
        repeat (4) @(posedge ap_clk);
        areset_generator <= 1'b0;

        // Ascending with left shift
        send_config(make_config(32'h0000_1000, 3, 40, 5, 1'b0, 1'b1, 2));
        wait_done();

        // Descending, right shift, zero stride
        send_config(make_config(32'h0000_8000, 30, 10, 0, 1'b1, 1'b0, 1));
        wait_done();

        // --------------------
        // Back-pressure, then an empty range queued behind the running job
        // --------------------
        @(posedge ap_clk);
        hold_rd <= 1'b1;
        send_config(make_config(32'h2000_0000, 0, 100, 3, 1'b0, 1'b1, 4));
        @(posedge ap_clk);
        cfg     <= make_config(32'h0000_4000, 7, 7, 2, 1'b0, 1'b1, 0);
        cfg_req <= 1'b1;
        repeat (40) @(posedge ap_clk);
        hold_rd <= 1'b0;
        wait_ack(1'b1, "rise");
        cfg_req <= 1'b0;
        wait_ack(1'b0, "fall");
        wait_done();

        repeat (5) @(posedge ap_clk);
        if (dut_i.assert_i.error_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("Checker errors were reported");
        end
    end

endmodule : csr_index_gen_tb

//--- csr_index_gen.f
hdl/csr_index_pkg.sv
hdl/range_decode.sv
hdl/index_sequencer.sv
hdl/request_queue.sv
hdl/csr_index_gen_top.sv
test/csr_index_gen_assert.sv
test/csr_index_gen_tb.sv
